/* filelist.f */
design/core_pkg.sv
design/stage_reg.sv
design/reg_file.sv
design/hazard_ctrl.sv
design/fetch_decode.sv
design/exec_unit.sv
design/pipe_core.sv
verification/pipe_core_chk.sv
verification/tb_pipe_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipelined core simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_pipe_core -f filelist.f \
    --Mdir obj_dir -o sim_pipe_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pipe_core +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

/* verification/tb_pipe_core.sv */
// Pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core import core_pkg::*; ();

    localparam word_t RESET_PC = 16'h0010;
    localparam int    N_DIR    = 6;
    localparam int    N_RAND   = 66;
    localparam int    PROG_LEN = 80;
    localparam int    TIMEOUT  = 2000;

    logic  clk;
    logic  rst;
    word_t inst;
    word_t mem_rd_data;
    word_t pc;
    word_t mem_addr;
    word_t mem_wr_data;
    logic  mem_wr_en;

    word_t       rom [128];
    word_t       dmem [64];
    logic [31:0] seed;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       exp_hold [$];
    word_t       exp_a;
    word_t       exp_d;
    word_t       prev_pc;
    logic        pc_seen;
    int          stores_taken;
    int          n_exp_stores;
    int          mismatch_errs;
    int          other_errs;
    int          chk_errs;
    int          waited;

    pipe_core #(.RESET_PC(RESET_PC)) pipe_core_i (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_inst        (inst),
        .i_mem_rd_data (mem_rd_data),
        .o_pc          (pc),
        .o_mem_addr    (mem_addr),
        .o_mem_wr_data (mem_wr_data),
        .o_mem_wr_en   (mem_wr_en)
    );

    bind pipe_core pipe_core_chk #(.RESET_PC(RESET_PC)) chk_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pc          (o_pc),
        .i_mem_wr_en   (o_mem_wr_en),
        .i_stall       (stall),
        .i_bubble_ex   (bubble_ex),
        .i_fetch_valid (fetch_valid),
        .i_dec_valid   (dec_valid),
        .i_ex_valid    (ex_valid),
        .i_wb_valid    (wb_valid)
    );

    always #2 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Initial data memory contents over the whole address
    function automatic word_t fill_word(logic [5:0] a);
        return {a, a, a[3:0]} ^ 16'h5a3c;
    endfunction

    function automatic word_t rom_read(word_t addr);
        word_t off;
        off = addr - RESET_PC;
        return (off[15:7] == '0) ? rom[off[6:0]] : '0;
    endfunction

    // Half the time a register that was just written
    function automatic reg_addr_t pick_reg(logic [3:0] bits, reg_addr_t rec0, reg_addr_t rec1);
        if (!bits[3]) begin
            return bits[2:0];
        end
        return bits[0] ? rec0 : rec1;
    endfunction

    // Source registers of an instruction per the ISA
    function automatic logic reads_reg(word_t w, reg_addr_t r);
        logic hit;
        case (opcode_t'(w[15:13]))
            OP_ADD, OP_NAND: hit = (w[9:7] == r) || (w[2:0] == r);
            OP_ADDI, OP_LW:  hit = (w[9:7] == r);
            OP_SW:           hit = (w[9:7] == r) || (w[12:10] == r);
            default:         hit = 1'b0;
        endcase
        return hit;
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] s;
        opcode_t     op;
        reg_addr_t   a;
        reg_addr_t   b;
        reg_addr_t   c;
        reg_addr_t   rec0;
        reg_addr_t   rec1;
        rec0 = 3'd4;
        rec1 = 3'd3;
        for (int i = 0; i < 128; i++) begin
            rom[i[6:0]] = '0;
        end
        // Directed start with LUI, negative ADDI, write to r0, store and load-use
        rom[0] = {OP_LUI, 3'd1, 10'h2a5};
        rom[1] = {OP_ADDI, 3'd2, 3'd1, 7'h7d};
        rom[2] = {OP_ADD, 3'd0, 3'd1, 4'b0, 3'd2};
        rom[3] = {OP_SW, 3'd2, 3'd0, 7'd5};
        rom[4] = {OP_LW, 3'd3, 3'd0, 7'd5};
        rom[5] = {OP_ADD, 3'd4, 3'd3, 4'b0, 3'd1};
        for (int i = 0; i < N_RAND; i++) begin
            seed = lcg_next(seed);
            r = seed;
            seed = lcg_next(seed);
            s = seed;
            case (r[31:29])
                3'd0:       op = OP_ADD;
                3'd1, 3'd7: op = OP_ADDI;
                3'd2:       op = OP_NAND;
                3'd3:       op = OP_LUI;
                3'd4:       op = OP_SW;
                default:    op = OP_LW;
            endcase
            a = r[28:26];
            b = pick_reg(r[25:22], rec0, rec1);
            c = pick_reg(r[21:18], rec0, rec1);
            case (op)
                OP_ADD, OP_NAND: rom[7'(N_DIR + i)] = {op, a, b, 4'b0, c};
                OP_LUI:          rom[7'(N_DIR + i)] = {op, a, s[31:22]};
                OP_SW:           rom[7'(N_DIR + i)] = {op, c, b, s[31:25]};
                default:         rom[7'(N_DIR + i)] = {op, a, b, s[31:25]};
            endcase
            if (op != OP_SW) begin
                rec1 = rec0;
                rec0 = a;
            end
        end
        // Dump r0..r7 to words 56..63
        for (int k = 0; k < 8; k++) begin
            rom[7'(N_DIR + N_RAND + k)] = {OP_SW, k[2:0], 3'd0, 7'(56 + k)};
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    task automatic build_expected();
        word_t     regs [8];
        word_t     mem [64];
        word_t     w;
        word_t     rb;
        word_t     addr;
        word_t     res;
        reg_addr_t ra;
        logic      we;
        for (int i = 0; i < 8; i++) begin
            regs[i[2:0]] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i[5:0]] = fill_word(i[5:0]);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w    = rom[i[6:0]];
            ra   = w[12:10];
            rb   = regs[w[9:7]];
            addr = rb + {{9{w[6]}}, w[6:0]};
            we   = 1'b1;
            res  = '0;
            case (opcode_t'(w[15:13]))
                OP_ADD:  res = rb + regs[w[2:0]];
                OP_ADDI: res = addr;
                OP_NAND: res = ~(rb & regs[w[2:0]]);
                OP_LUI:  res = {w[9:0], 6'b0};
                OP_LW:   res = mem[addr[5:0]];
                OP_SW: begin
                    we = 1'b0;
                    mem[addr[5:0]] = regs[ra];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[ra]);
                end
                default: we = 1'b0;
            endcase
            if (we && (ra != '0)) begin
                regs[ra] = res;
            end
            // Consumer right behind a load waits one cycle in decode
            if ((opcode_t'(w[15:13]) == OP_LW) && (ra != '0) && (i + 1 < PROG_LEN) &&
                reads_reg(rom[7'(i + 1)], ra)) begin
                exp_hold.push_back(RESET_PC + 16'(i + 3));
            end
        end
    endtask

    // ------------------------------
    // Memories and monitors
    // ------------------------------

    always @(posedge clk) begin
        if (mem_wr_en) begin
            dmem[mem_addr[5:0]] <= mem_wr_data;
        end
    end

    always @(negedge clk) begin
        inst        <= rom_read(pc);
        mem_rd_data <= dmem[mem_addr[5:0]];
        if (mem_wr_en) begin
            stores_taken++;
            assert (exp_addr.size() > 0) else begin
                $display("Store to %h at %0t beyond the end of the program", mem_addr, $time);
                other_errs++;
            end
            if (exp_addr.size() > 0) begin
                exp_a = exp_addr.pop_front();
                exp_d = exp_data.pop_front();
                assert (mem_addr == exp_a) else begin
                    $display("MISMATCH t=%0t o_mem_addr exp=%h got=%h", $time, exp_a, mem_addr);
                    mismatch_errs++;
                end
                assert (mem_wr_data == exp_d) else begin
                    $display("MISMATCH t=%0t o_mem_wr_data exp=%h got=%h",
                             $time, exp_d, mem_wr_data);
                    mismatch_errs++;
                end
            end
        end
        if (!rst && pc_seen && (pc == prev_pc)) begin
            assert ((exp_hold.size() > 0) && (exp_hold[0] == pc)) else begin
                $display("PC held at %h at %0t with no load-use hazard there", pc, $time);
                other_errs++;
            end
            if ((exp_hold.size() > 0) && (exp_hold[0] == pc)) begin
                void'(exp_hold.pop_front());
            end
        end
        pc_seen = !rst;
        prev_pc = pc;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        inst          = '0;
        mem_rd_data   = '0;
        pc_seen       = 1'b0;
        prev_pc       = '0;
        stores_taken  = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        chk_errs      = 0;
        seed          = 32'hd855;
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] <= fill_word(i[5:0]);
        end
        gen_program();
        build_expected();
        n_exp_stores = exp_addr.size();

        repeat (8) @(negedge clk);
        rst <= 1'b0;

        waited = 0;
        while ((exp_addr.size() > 0) && (waited < TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        if (exp_addr.size() > 0) begin
            $display("Timeout with %0d stores still outstanding", exp_addr.size());
            other_errs++;
        end

        // Let any stray store show up
        repeat (12) @(negedge clk);
        if (stores_taken != n_exp_stores) begin
            $display("Took %0d stores, program has %0d", stores_taken, n_exp_stores);
            other_errs++;
        end
        if (exp_hold.size() > 0) begin
            $display("Expected load-use stall at PC %h never happened", exp_hold[0]);
            other_errs++;
        end
        chk_errs = pipe_core_i.chk_i.fail_count;

        $display("Errors: mismatch=%0d other=%0d checker=%0d stores=%0d",
                 mismatch_errs, other_errs, chk_errs, stores_taken);
        if ((mismatch_errs + other_errs + chk_errs) == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/pipe_core_chk.sv */
// Pipeline stall and bubble checks
`timescale 1ns/1ps
`default_nettype none

module pipe_core_chk import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input wire logic  i_clk,
    input wire logic  i_rst,
    input wire word_t i_pc,
    input wire logic  i_mem_wr_en,
    input wire logic  i_stall,
    input wire logic  i_bubble_ex,
    input wire logic  i_fetch_valid,
    input wire logic  i_dec_valid,
    input wire logic  i_ex_valid,
    input wire logic  i_wb_valid
);

    int fail_count = 0;

    // ------------------------------
    // Reset state
    // ------------------------------

    reset_state_a: assert property (@(posedge i_clk)
        i_rst |=> (i_pc == RESET_PC) && !i_mem_wr_en && !i_stall && !i_bubble_ex &&
                  !i_fetch_valid && !i_dec_valid && !i_ex_valid && !i_wb_valid)
        else begin
            fail_count++;
            $error("Core not in its reset state after reset");
        end

    // ------------------------------
    // Stall and bubble flow
    // ------------------------------

    // A load-use stall lasts one cycle only
    stall_once_a: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stall |=> !i_stall)
        else begin
            fail_count++;
            $error("Stall held for more than one cycle");
        end

    bubble_empty_a: assert property (@(posedge i_clk) disable iff (i_rst)
        i_bubble_ex |=> !i_ex_valid)
        else begin
            fail_count++;
            $error("Execute register valid after a bubble");
        end

    pc_hold_a: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stall |=> (i_pc == $past(i_pc)))
        else begin
            fail_count++;
            $error("PC moved during a stall");
        end

    pc_step_a: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_stall |=> (i_pc == $past(i_pc) + 16'd1))
        else begin
            fail_count++;
            $error("PC did not advance by one");
        end

endmodule

`default_nettype wire

/* design/pipe_core.sv */
// Five-stage pipelined core
`timescale 1ns/1ps
`default_nettype none

module pipe_core import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire word_t i_inst,
    input  wire word_t i_mem_rd_data,
    output      word_t o_pc,
    output      word_t o_mem_addr,
    output      word_t o_mem_wr_data,
    output      logic  o_mem_wr_en
);

    fetch_pl_t  fetch_next;
    fetch_pl_t  fetch_q;
    logic       fetch_valid;
    decode_pl_t dec_next;
    decode_pl_t dec_q;
    logic       dec_valid;
    exec_pl_t   ex_next;
    exec_pl_t   ex_q;
    logic       ex_valid;
    wb_pl_t     wb_next;
    wb_pl_t     wb_q;
    logic       wb_valid;
    reg_addr_t  rd_src_a;
    reg_addr_t  rd_src_b;
    word_t      rd_a;
    word_t      rd_b;
    word_t      mem_result;
    logic       stall;
    logic       bubble_ex;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;

    // ------------------------------
    // Control and register file
    // ------------------------------

    hazard_ctrl hazard_i (
        .i_dec       (dec_q),
        .i_dec_valid (dec_valid),
        .i_ex        (ex_q),
        .i_ex_valid  (ex_valid),
        .i_mem_tgt   (ex_q.tgt),
        .i_wb_tgt    (wb_q.tgt),
        .o_stall     (stall),
        .o_bubble_ex (bubble_ex),
        .o_fwd_a     (fwd_a),
        .o_fwd_b     (fwd_b)
    );

    reg_file reg_file_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_src_a   (rd_src_a),
        .i_src_b   (rd_src_b),
        .i_wr_en   (ex_valid),
        .i_wr_tgt  (ex_q.tgt),
        .i_wr_data (mem_result),
        .o_data_a  (rd_a),
        .o_data_b  (rd_b)
    );

    // ------------------------------
    // Stages
    // ------------------------------

    fetch_decode #(.RESET_PC(RESET_PC)) fetch_decode_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_inst        (i_inst),
        .i_stall       (stall),
        .i_fetch       (fetch_q),
        .i_fetch_valid (fetch_valid),
        .i_dec         (dec_q),
        .i_rd_a        (rd_a),
        .i_rd_b        (rd_b),
        .o_pc          (o_pc),
        .o_fetch_next  (fetch_next),
        .o_rd_src_a    (rd_src_a),
        .o_rd_src_b    (rd_src_b),
        .o_dec_next    (dec_next)
    );

    exec_unit exec_i (
        .i_dec         (dec_q),
        .i_fwd_a       (fwd_a),
        .i_fwd_b       (fwd_b),
        .i_ex_result   (ex_q.result),
        .i_wb_result   (wb_q.result),
        .i_mem         (ex_q),
        .i_mem_rd_data (i_mem_rd_data),
        .o_ex_next     (ex_next),
        .o_wb_next     (wb_next),
        .o_mem_result  (mem_result)
    );

    stage_reg #(.payload_t(fetch_pl_t)) fetch_reg_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_hold   (stall),
        .i_bubble (1'b0),
        .i_valid  (1'b1),
        .i_data   (fetch_next),
        .o_valid  (fetch_valid),
        .o_data   (fetch_q)
    );

    // On a stall dec_next already carries the held entry
    stage_reg #(.payload_t(decode_pl_t)) dec_reg_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_hold   (1'b0),
        .i_bubble (1'b0),
        .i_valid  (fetch_valid),
        .i_data   (dec_next),
        .o_valid  (dec_valid),
        .o_data   (dec_q)
    );

    stage_reg #(.payload_t(exec_pl_t)) ex_reg_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_hold   (1'b0),
        .i_bubble (bubble_ex),
        .i_valid  (dec_valid),
        .i_data   (ex_next),
        .o_valid  (ex_valid),
        .o_data   (ex_q)
    );

    stage_reg #(.payload_t(wb_pl_t)) wb_reg_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_hold   (1'b0),
        .i_bubble (1'b0),
        .i_valid  (ex_valid),
        .i_data   (wb_next),
        .o_valid  (wb_valid),
        .o_data   (wb_q)
    );

    // Data port straight from the execute register
    assign o_mem_addr    = ex_q.result;
    assign o_mem_wr_data = ex_q.st_data;
    assign o_mem_wr_en   = ex_valid && (ex_q.opcode == OP_SW);

endmodule

`default_nettype wire

/* design/exec_unit.sv */
// Execute and memory result logic
`timescale 1ns/1ps
`default_nettype none

module exec_unit import core_pkg::*; (
    input  wire decode_pl_t i_dec,
    input  wire fwd_sel_t   i_fwd_a,
    input  wire fwd_sel_t   i_fwd_b,
    input  wire word_t      i_ex_result,
    input  wire word_t      i_wb_result,
    input  wire exec_pl_t   i_mem,
    input  wire word_t      i_mem_rd_data,
    output      exec_pl_t   o_ex_next,
    output      wb_pl_t     o_wb_next,
    output      word_t      o_mem_result
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t dec_val, word_t ex_val,
                                      word_t mem_val, word_t wb_val);
        word_t val;
        case (sel)
            FWD_EX:   val = ex_val;
            FWD_MEM:  val = mem_val;
            FWD_WB:   val = wb_val;
            FWD_ZERO: val = '0;
            default:  val = dec_val;
        endcase
        return val;
    endfunction

    // ------------------------------
    // Memory stage result
    // ------------------------------

    assign o_mem_result = (i_mem.opcode == OP_LW) ? i_mem_rd_data : i_mem.result;

    assign o_wb_next = '{tgt: i_mem.tgt, result: o_mem_result};

    // ------------------------------
    // Execute
    // ------------------------------

    always_comb begin
        op_a = fwd_mux(i_fwd_a, i_dec.op_a, i_ex_result, o_mem_result, i_wb_result);
        op_b = fwd_mux(i_fwd_b, i_dec.op_b, i_ex_result, o_mem_result, i_wb_result);
    end

    // Address computation shares the adder with ADDI
    always_comb begin
        case (i_dec.opcode)
            OP_ADD:                alu_out = op_a + op_b;
            OP_ADDI, OP_LW, OP_SW: alu_out = op_a + i_dec.imm;
            OP_NAND:               alu_out = ~(op_a & op_b);
            OP_LUI:                alu_out = i_dec.imm;
            default:               alu_out = '0;
        endcase
    end

    // Store data rides along as the second operand
    assign o_ex_next = '{
        opcode:  i_dec.opcode,
        tgt:     i_dec.tgt,
        result:  alu_out,
        st_data: op_b
    };

endmodule

`default_nettype wire

/* design/fetch_decode.sv */
// Fetch and decode stage
`timescale 1ns/1ps
`default_nettype none

module fetch_decode import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire word_t      i_inst,
    input  wire logic       i_stall,
    input  wire fetch_pl_t  i_fetch,
    input  wire logic       i_fetch_valid,
    input  wire decode_pl_t i_dec,
    input  wire word_t      i_rd_a,
    input  wire word_t      i_rd_b,
    output      word_t      o_pc,
    output      fetch_pl_t  o_fetch_next,
    output      reg_addr_t  o_rd_src_a,
    output      reg_addr_t  o_rd_src_b,
    output      decode_pl_t o_dec_next
);

    opcode_t   opcode;
    reg_addr_t reg_a;
    reg_addr_t reg_b;
    reg_addr_t reg_c;
    word_t     simm_ext;
    word_t     limm_ext;
    reg_addr_t tgt;
    reg_addr_t src_a;
    reg_addr_t src_b;
    word_t     imm;

    // ------------------------------
    // Fetch
    // ------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= RESET_PC;
        end else if (!i_stall) begin
            o_pc <= o_pc + 16'd1;
        end
    end

    assign o_fetch_next = '{inst: i_inst};

    // ------------------------------
    // Decode
    // ------------------------------

    assign opcode   = opcode_t'(i_fetch.inst[15:13]);
    assign reg_a    = i_fetch.inst[12:10];
    assign reg_b    = i_fetch.inst[9:7];
    assign reg_c    = i_fetch.inst[2:0];
    assign simm_ext = {{9{i_fetch.inst[6]}}, i_fetch.inst[6:0]};
    assign limm_ext = {i_fetch.inst[9:0], 6'b0};

    // Empty fetch slot and branch opcodes decode as no-ops
    always_comb begin
        tgt   = '0;
        src_a = '0;
        src_b = '0;
        imm   = '0;
        if (i_fetch_valid) begin
            case (opcode)
                OP_ADD, OP_NAND: begin
                    tgt   = reg_a;
                    src_a = reg_b;
                    src_b = reg_c;
                end
                OP_ADDI, OP_LW: begin
                    tgt   = reg_a;
                    src_a = reg_b;
                    imm   = simm_ext;
                end
                OP_LUI: begin
                    tgt = reg_a;
                    imm = limm_ext;
                end
                OP_SW: begin
                    src_a = reg_b;
                    src_b = reg_a;
                    imm   = simm_ext;
                end
                default: begin
                    tgt = '0;
                end
            endcase
        end
    end

    // Held entry re-reads its sources, the file now has the writeback result
    assign o_rd_src_a = i_stall ? i_dec.src_a : src_a;
    assign o_rd_src_b = i_stall ? i_dec.src_b : src_b;

    always_comb begin
        if (i_stall) begin
            o_dec_next      = i_dec;
            o_dec_next.op_a = i_rd_a;
            o_dec_next.op_b = i_rd_b;
        end else begin
            o_dec_next = '{
                opcode: i_fetch_valid ? opcode : OP_ADD,
                tgt:    tgt,
                src_a:  src_a,
                src_b:  src_b,
                op_a:   i_rd_a,
                op_b:   i_rd_b,
                imm:    imm
            };
        end
    end

endmodule

`default_nettype wire

/* design/hazard_ctrl.sv */
// Load-use and forwarding control
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl import core_pkg::*; (
    input  wire decode_pl_t i_dec,
    input  wire logic       i_dec_valid,
    input  wire exec_pl_t   i_ex,
    input  wire logic       i_ex_valid,
    input  wire reg_addr_t  i_mem_tgt,
    input  wire reg_addr_t  i_wb_tgt,
    output      logic       o_stall,
    output      logic       o_bubble_ex,
    output      fwd_sel_t   o_fwd_a,
    output      fwd_sel_t   o_fwd_b
);

    logic ex_is_load;

    // Nearest producer wins
    function automatic fwd_sel_t pick_src(reg_addr_t src, reg_addr_t ex_tgt, logic ex_load,
                                          reg_addr_t mem_tgt, reg_addr_t wb_tgt);
        fwd_sel_t sel;
        if (src == '0) begin
            sel = FWD_ZERO;
        end else if ((src == ex_tgt) && !ex_load) begin
            sel = FWD_EX;
        end else if (src == mem_tgt) begin
            // Load in the memory stage gives its read data
            sel = FWD_MEM;
        end else if (src == wb_tgt) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_DEC;
        end
        return sel;
    endfunction

    assign ex_is_load = i_ex_valid && (i_ex.opcode == OP_LW);

    // Load-use hazard, the consumer waits one cycle in decode
    assign o_stall = i_dec_valid && ex_is_load && (i_ex.tgt != '0) &&
                     ((i_ex.tgt == i_dec.src_a) || (i_ex.tgt == i_dec.src_b));

    assign o_bubble_ex = o_stall;

    always_comb begin
        o_fwd_a = pick_src(i_dec.src_a, i_ex.tgt, ex_is_load, i_mem_tgt, i_wb_tgt);
        o_fwd_b = pick_src(i_dec.src_b, i_ex.tgt, ex_is_load, i_mem_tgt, i_wb_tgt);
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// Eight-entry register file
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire reg_addr_t i_src_a,
    input  wire reg_addr_t i_src_b,
    input  wire logic      i_wr_en,
    input  wire reg_addr_t i_wr_tgt,
    input  wire word_t     i_wr_data,
    output      word_t     o_data_a,
    output      word_t     o_data_b
);

    word_t regs [8];

    // Writes to register 0 are dropped
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_tgt != '0)) begin
            regs[i_wr_tgt] <= i_wr_data;
        end
    end

    // Asynchronous reads, register 0 is hardwired to zero
    assign o_data_a = (i_src_a == '0) ? '0 : regs[i_src_a];
    assign o_data_b = (i_src_b == '0) ? '0 : regs[i_src_b];

endmodule

`default_nettype wire

/* design/stage_reg.sv */
// Pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_hold,
    input  wire logic     i_bubble,
    input  wire logic     i_valid,
    input  wire payload_t i_data,
    output      logic     o_valid,
    output      payload_t o_data
);

    // An all-zero payload decodes as a no-op with target 0
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else if (i_hold) begin
            o_valid <= o_valid;
            o_data  <= o_data;
        end else if (i_bubble) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            o_valid <= i_valid;
            o_data  <= i_data;
        end
    end

endmodule

`default_nettype wire

/* design/core_pkg.sv */
// Core shared types
`default_nettype none

package core_pkg;

    // Data, address and instruction words
    typedef logic [15:0] word_t;

    // Register index, eight registers
    typedef logic [2:0] reg_addr_t;

    // Opcode numbering of the instruction set
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_ADDI = 3'd1,
        OP_NAND = 3'd2,
        OP_LUI  = 3'd3,
        OP_SW   = 3'd4,
        OP_LW   = 3'd5,
        OP_BEQ  = 3'd6,
        OP_JALR = 3'd7
    } opcode_t;

    // Operand source picked by the forwarding logic
    typedef enum logic [2:0] {
        FWD_DEC  = 3'd0,
        FWD_EX   = 3'd1,
        FWD_MEM  = 3'd2,
        FWD_WB   = 3'd3,
        FWD_ZERO = 3'd4
    } fwd_sel_t;

    // ------------------------------
    // Stage payloads
    // ------------------------------

    typedef struct packed {
        word_t inst;
    } fetch_pl_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t tgt;
        reg_addr_t src_a;
        reg_addr_t src_b;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
    } decode_pl_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t tgt;
        word_t     result;
        word_t     st_data;
    } exec_pl_t;

    // Result heading for the register file
    typedef struct packed {
        reg_addr_t tgt;
        word_t     result;
    } wb_pl_t;

endpackage

`default_nettype wire
